//--- sources.f
+incdir+sim
design/mfPkg.sv
design/coeffStore.sv
design/sampleFifo.sv
design/complexFir.sv
design/magnitudeStage.sv
design/matchedFilterTop.sv
sim/tbMatchedFilter.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tbMatchedFilter -Mdir obj_dir
	./obj_dir/VtbMatchedFilter

clean:
	rm -rf obj_dir

//--- sim/mfModel.svh
`ifndef MF_MODEL_SVH
`define MF_MODEL_SVH

// coefficients of the set that is loaded or about to be loaded
longint refCoefRe [mfPkg::NUM_TAPS];
longint refCoefIm [mfPkg::NUM_TAPS];

// model history, x[n-k] sits in slot k
longint refHistRe [mfPkg::NUM_TAPS];
longint refHistIm [mfPkg::NUM_TAPS];

function automatic void clearHistory();
	for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
		refHistRe[k] = 0;
		refHistIm[k] = 0;
	end
endfunction

// keeps the low OUT_WIDTH bits of a shifted sum as a signed number
function automatic longint toOut(input longint v);
	logic signed [mfPkg::OUT_WIDTH-1:0] t;
	t = v[mfPkg::OUT_WIDTH-1:0];
	return longint'(t);
endfunction

function automatic longint absVal(input longint v);
	return (v < 0) ? -v : v;
endfunction

// y[n] = sum over k of conj(h[k]) * x[n-k], the new sample enters as x[n]
function automatic longint refFilter(input longint re, input longint im);
	longint sumRe;
	longint sumIm;
	for (int k = mfPkg::NUM_TAPS - 1; k > 0; k--) begin
		refHistRe[k] = refHistRe[k-1];
		refHistIm[k] = refHistIm[k-1];
	end
	refHistRe[0] = re;
	refHistIm[0] = im;
	sumRe = 0;
	sumIm = 0;
	for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
		// (a - jb)(c + jd) = (ac + bd) + j(ad - bc)
		sumRe += refCoefRe[k] * refHistRe[k] + refCoefIm[k] * refHistIm[k];
		sumIm += refCoefRe[k] * refHistIm[k] - refCoefIm[k] * refHistRe[k];
	end
	return absVal(toOut(sumRe >>> mfPkg::FRAC_SHIFT)) + absVal(toOut(sumIm >>> mfPkg::FRAC_SHIFT));
endfunction

task automatic checkValue(input string name, input longint got, input longint expected);
	if (got != expected) begin
		failRun($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected));
	end
endtask

`endif

//--- sim/tbMatchedFilter.sv
`timescale 1ns/1ps

module tbMatchedFilter;

	localparam int PLANNED_SAMPLES = 210; // 8 impulse, 100, 60, 12, then 10 and 20 around the flush
	localparam int TIMEOUT_CYCLES  = 30 * PLANNED_SAMPLES + 200;
	localparam logic signed [mfPkg::DATA_WIDTH-1:0] FULL_SCALE = 16'sh7fff;

	logic                                clock;
	logic                                rstN;
	logic                                flush;
	logic                                coeffValid;
	logic                                coeffReady;
	logic signed [mfPkg::DATA_WIDTH-1:0] coeffRe;
	logic signed [mfPkg::DATA_WIDTH-1:0] coeffIm;
	logic                                inValid;
	logic                                inReady;
	logic signed [mfPkg::DATA_WIDTH-1:0] inRe;
	logic signed [mfPkg::DATA_WIDTH-1:0] inIm;
	logic                                outValid;
	logic                                outReady;
	logic [mfPkg::MAG_WIDTH-1:0]         outMag;

	int     seed = 32'h27eb_0127;
	int     readyPct; // chance in percent that outReady is high in a cycle
	int     cycleCount;
	int     modelTaps; // coefficients accepted since reset or the last flush
	bit     sawFull;
	longint expQ [$];
	longint seenMag [$];
	logic signed [mfPkg::DATA_WIDTH-1:0] nextRe [mfPkg::NUM_TAPS];
	logic signed [mfPkg::DATA_WIDTH-1:0] nextIm [mfPkg::NUM_TAPS];

	matchedFilterTop dut_i (
		.clock      (clock),
		.rstN       (rstN),
		.flush      (flush),
		.coeffValid (coeffValid),
		.coeffReady (coeffReady),
		.coeffRe    (coeffRe),
		.coeffIm    (coeffIm),
		.inValid    (inValid),
		.inReady    (inReady),
		.inRe       (inRe),
		.inIm       (inIm),
		.outValid   (outValid),
		.outReady   (outReady),
		.outMag     (outMag)
	);

	always #2 clock = ~clock;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped after a failure");
	endtask

	`include "mfModel.svh"

	function automatic int randPct();
		return int'({$random(seed)} % 100);
	endfunction

	function automatic logic signed [mfPkg::DATA_WIDTH-1:0] randData();
		logic [31:0] r;
		r = $random(seed);
		return r[mfPkg::DATA_WIDTH-1:0];
	endfunction

	// one tap of the response to a real full-scale impulse
	function automatic longint impulseMag(input int k);
		longint re;
		longint im;
		re = (refCoefRe[k] * longint'(FULL_SCALE)) >>> mfPkg::FRAC_SHIFT;
		im = (-refCoefIm[k] * longint'(FULL_SCALE)) >>> mfPkg::FRAC_SHIFT;
		return absVal(toOut(re)) + absVal(toOut(im));
	endfunction

	// ------------------------------
	// drivers that are called 1 ns after an edge
	// ------------------------------
	task automatic loadCoeffs();
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			refCoefRe[k] = longint'(nextRe[k]);
			refCoefIm[k] = longint'(nextIm[k]);
		end
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			coeffValid = 1'b1;
			coeffRe    = nextRe[k];
			coeffIm    = nextIm[k];
			@(posedge clock);
			while (!coeffReady) @(posedge clock);
			#1;
		end
		coeffValid = 1'b0;
	endtask

	task automatic sendOne(input logic signed [mfPkg::DATA_WIDTH-1:0] re,
	                       input logic signed [mfPkg::DATA_WIDTH-1:0] im, input int idlePct);
		while (randPct() < idlePct) begin
			inValid = 1'b0;
			@(posedge clock);
			#1;
		end
		inValid = 1'b1;
		inRe    = re;
		inIm    = im;
		@(posedge clock);
		while (!inReady) @(posedge clock);
		#1;
		inValid = 1'b0;
	endtask

	task automatic sendRandom(input int n, input int idlePct);
		for (int i = 0; i < n; i++) begin
			sendOne(randData(), randData(), idlePct);
		end
	endtask

	task automatic fillRandomSet();
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			nextRe[k] = randData();
			nextIm[k] = randData();
		end
	endtask

	task automatic pulseFlush();
		flush      = 1'b1;
		inValid    = 1'b0;
		coeffValid = 1'b0;
		@(posedge clock);
		#1;
		flush = 1'b0;
	endtask

	task automatic drain();
		while (expQ.size() != 0) @(posedge clock);
		#1;
	endtask

	always @(posedge clock) begin
		#1;
		outReady = (randPct() < readyPct);
	end

	// ------------------------------
	// scoreboard and timeout
	// ------------------------------
	always @(posedge clock) begin
		if (rstN) begin
			if (outValid && outReady) begin
				if (modelTaps < mfPkg::NUM_TAPS) begin
					failRun("a result came out before the coefficient set was complete");
				end else if (expQ.size() == 0) begin
					failRun("a result came out with no sample outstanding");
				end else begin
					checkValue("outMag", longint'(outMag), expQ.pop_front());
					seenMag.push_back(longint'(outMag));
				end
			end
			if (coeffValid && coeffReady) modelTaps++;
			if (inValid && inReady) expQ.push_back(refFilter(longint'(inRe), longint'(inIm)));
			if (inValid && !inReady && !flush) sawFull = 1'b1; // only a full FIFO refuses
			if (flush) begin
				expQ.delete(); // in-flight results are dropped by the DUT
				clearHistory();
				modelTaps = 0;
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) failRun("timeout: the run did not finish in time");
	end

	initial begin
		clock      = 1'b0;
		rstN       = 1'b0;
		flush      = 1'b0;
		coeffValid = 1'b0;
		coeffRe    = '0;
		coeffIm    = '0;
		inValid    = 1'b0;
		inRe       = '0;
		inIm       = '0;
		outReady   = 1'b0;
		readyPct   = 100;
		cycleCount = 0;
		modelTaps  = 0;
		sawFull    = 1'b0;
		clearHistory();
		repeat (4) @(posedge clock);
		#1;
		rstN = 1'b1;
		checkValue("coeffReady", coeffReady, 1);
		checkValue("inReady", inReady, 1);
		checkValue("outValid", outValid, 0);

		// impulse response gives the conjugated taps in order
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			nextRe[k] = mfPkg::DATA_WIDTH'(1000 * (k + 1));
			nextIm[k] = mfPkg::DATA_WIDTH'(300 - 700 * k);
		end
		loadCoeffs();
		seenMag.delete();
		sendOne(FULL_SCALE, '0, 0);
		repeat (mfPkg::NUM_TAPS - 1) sendOne('0, '0, 0);
		drain();
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			checkValue("outMag", seenMag[k], impulseMag(k));
		end

		sendRandom(100, 0);
		drain();

		readyPct = 30; // slow sink so the FIFO fills up
		sendRandom(60, 30);
		readyPct = 100;
		drain();
		if (!sawFull) failRun("inReady never dropped while the FIFO was full");

		// samples are offered while the new set is still loading
		pulseFlush();
		fillRandomSet();
		fork
			loadCoeffs();
			sendRandom(12, 0);
		join
		drain();

		readyPct = 20;
		sendRandom(10, 0);
		pulseFlush();
		readyPct = 100;
		fillRandomSet();
		loadCoeffs();
		sendRandom(20, 10);
		drain();

		repeat (5) @(posedge clock);
		if (expQ.size() == 0 && !outValid) begin
			$display("TEST PASS");
			$finish;
		end else begin
			failRun("results were left over at the end of the run");
		end
	end

endmodule

//--- design/matchedFilterTop.sv
`timescale 1ns/1ps

module matchedFilterTop (
	input  logic                                clock,
	input  logic                                rstN,
	input  logic                                flush,

	// coefficient stream, h[0] first
	input  logic                                coeffValid,
	output logic                                coeffReady,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] coeffRe,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] coeffIm,

	// sample stream
	input  logic                                inValid,
	output logic                                inReady,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] inRe,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] inIm,

	// result stream
	output logic                                outValid,
	input  logic                                outReady,
	output logic [mfPkg::MAG_WIDTH-1:0]         outMag
);

	// ------------------------------
	// internal nets
	// ------------------------------
	logic                                coeffsLoaded;
	logic signed [mfPkg::DATA_WIDTH-1:0] coefRe [mfPkg::NUM_TAPS];
	logic signed [mfPkg::DATA_WIDTH-1:0] coefIm [mfPkg::NUM_TAPS];

	logic                                fifoValid;
	logic                                fifoReady;
	logic signed [mfPkg::DATA_WIDTH-1:0] fifoRe;
	logic signed [mfPkg::DATA_WIDTH-1:0] fifoIm;

	logic                                firValid;
	logic                                firReady;
	logic signed [mfPkg::OUT_WIDTH-1:0]  firRe;
	logic signed [mfPkg::OUT_WIDTH-1:0]  firIm;

	coeffStore coeffStore_i (
		.clock        (clock),
		.rstN         (rstN),
		.flush        (flush),
		.coeffValid   (coeffValid),
		.coeffReady   (coeffReady),
		.coeffRe      (coeffRe),
		.coeffIm      (coeffIm),
		.coeffsLoaded (coeffsLoaded),
		.coefRe       (coefRe),
		.coefIm       (coefIm)
	);

	sampleFifo sampleFifo_i (
		.clock     (clock),
		.rstN      (rstN),
		.flush     (flush),
		.inValid   (inValid),
		.inReady   (inReady),
		.inRe      (inRe),
		.inIm      (inIm),
		.fifoValid (fifoValid),
		.fifoReady (fifoReady),
		.fifoRe    (fifoRe),
		.fifoIm    (fifoIm)
	);

	// the FIR and the magnitude stage form the two-stage consumer pipeline
	complexFir complexFir_i (
		.clock        (clock),
		.rstN         (rstN),
		.flush        (flush),
		.coeffsLoaded (coeffsLoaded),
		.coefRe       (coefRe),
		.coefIm       (coefIm),
		.fifoValid    (fifoValid),
		.fifoReady    (fifoReady),
		.fifoRe       (fifoRe),
		.fifoIm       (fifoIm),
		.firValid     (firValid),
		.firReady     (firReady),
		.firRe        (firRe),
		.firIm        (firIm)
	);

	magnitudeStage magnitudeStage_i (
		.clock    (clock),
		.rstN     (rstN),
		.flush    (flush),
		.firValid (firValid),
		.firReady (firReady),
		.firRe    (firRe),
		.firIm    (firIm),
		.outValid (outValid),
		.outReady (outReady),
		.outMag   (outMag)
	);

endmodule

//--- design/magnitudeStage.sv
`timescale 1ns/1ps

module magnitudeStage (
	input  logic                               clock,
	input  logic                               rstN,
	input  logic                               flush,

	input  logic                               firValid,
	output logic                               firReady,
	input  logic signed [mfPkg::OUT_WIDTH-1:0] firRe,
	input  logic signed [mfPkg::OUT_WIDTH-1:0] firIm,

	output logic                               outValid,
	input  logic                               outReady,
	output logic [mfPkg::MAG_WIDTH-1:0]        outMag
);

	logic signed [mfPkg::MAG_WIDTH-1:0] extRe;
	logic signed [mfPkg::MAG_WIDTH-1:0] extIm;
	logic        [mfPkg::MAG_WIDTH-1:0] absRe;
	logic        [mfPkg::MAG_WIDTH-1:0] absIm;
	logic                               resultAccept;

	assign firReady     = !flush && (!outValid || outReady);
	assign resultAccept = firValid && firReady;

	// widen first so negating the most negative component cannot wrap
	assign extRe = firRe;
	assign extIm = firIm;
	assign absRe = extRe[mfPkg::MAG_WIDTH-1] ? -extRe : extRe;
	assign absIm = extIm[mfPkg::MAG_WIDTH-1] ? -extIm : extIm;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (flush) begin
			outValid <= 1'b0; // whatever is in flight is dropped
		end else if (resultAccept) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (resultAccept) begin
			outMag <= absRe + absIm; // L1 norm stands in for the true magnitude
		end
	end

endmodule

//--- design/complexFir.sv
`timescale 1ns/1ps

module complexFir (
	input  logic                                clock,
	input  logic                                rstN,
	input  logic                                flush,

	input  logic                                coeffsLoaded,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] coefRe [mfPkg::NUM_TAPS],
	input  logic signed [mfPkg::DATA_WIDTH-1:0] coefIm [mfPkg::NUM_TAPS],

	input  logic                                fifoValid,
	output logic                                fifoReady,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] fifoRe,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] fifoIm,

	output logic                                firValid,
	input  logic                                firReady,
	output logic signed [mfPkg::OUT_WIDTH-1:0]  firRe,
	output logic signed [mfPkg::OUT_WIDTH-1:0]  firIm
);

	mfPkg::filterStateT state;

	// older samples only while the window below puts the incoming one in front
	logic signed [mfPkg::DATA_WIDTH-1:0] histRe [mfPkg::NUM_TAPS-1];
	logic signed [mfPkg::DATA_WIDTH-1:0] histIm [mfPkg::NUM_TAPS-1];
	logic signed [mfPkg::DATA_WIDTH-1:0] winRe  [mfPkg::NUM_TAPS];
	logic signed [mfPkg::DATA_WIDTH-1:0] winIm  [mfPkg::NUM_TAPS];

	logic signed [mfPkg::ACC_WIDTH-1:0] accRe;
	logic signed [mfPkg::ACC_WIDTH-1:0] accIm;
	logic signed [mfPkg::ACC_WIDTH-1:0] shiftRe;
	logic signed [mfPkg::ACC_WIDTH-1:0] shiftIm;
	logic                               sampleAccept;

	// pull only when the output register is free or empties on this edge
	assign fifoReady    = (state == mfPkg::RUN) && !flush && (!firValid || firReady);
	assign sampleAccept = fifoValid && fifoReady;

	// ------------------------------
	// control FSM
	// ------------------------------
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= mfPkg::IDLE;
		end else if (flush) begin
			state <= mfPkg::IDLE;
		end else begin
			case (state)
				mfPkg::IDLE: if (coeffsLoaded) state <= mfPkg::RUN;
				default:     state <= mfPkg::RUN; // stays until the next flush
			endcase
		end
	end

	// ------------------------------
	// correlation
	// ------------------------------
	always_comb begin
		winRe[0] = fifoRe; // x[n]
		winIm[0] = fifoIm;
		for (int k = 1; k < mfPkg::NUM_TAPS; k++) begin
			winRe[k] = histRe[k-1];
			winIm[k] = histIm[k-1];
		end
	end

	// conj(h) * x = (hr*xr + hi*xi) + j(hr*xi - hi*xr)
	always_comb begin
		logic signed [mfPkg::PROD_WIDTH-1:0] pRr;
		logic signed [mfPkg::PROD_WIDTH-1:0] pIi;
		logic signed [mfPkg::PROD_WIDTH-1:0] pRi;
		logic signed [mfPkg::PROD_WIDTH-1:0] pIr;
		accRe = '0;
		accIm = '0;
		for (int k = 0; k < mfPkg::NUM_TAPS; k++) begin
			pRr   = coefRe[k] * winRe[k];
			pIi   = coefIm[k] * winIm[k];
			pRi   = coefRe[k] * winIm[k];
			pIr   = coefIm[k] * winRe[k];
			accRe = accRe + mfPkg::ACC_WIDTH'(pRr) + mfPkg::ACC_WIDTH'(pIi);
			accIm = accIm + mfPkg::ACC_WIDTH'(pRi) - mfPkg::ACC_WIDTH'(pIr);
		end
	end

	assign shiftRe = accRe >>> mfPkg::FRAC_SHIFT;
	assign shiftIm = accIm >>> mfPkg::FRAC_SHIFT;

	// ------------------------------
	// history and output register
	// ------------------------------
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < mfPkg::NUM_TAPS - 1; k++) begin
				histRe[k] <= '0;
				histIm[k] <= '0;
			end
			firValid <= 1'b0;
		end else if (flush) begin
			// zeros make the first outputs after a flush behave like a cold start
			for (int k = 0; k < mfPkg::NUM_TAPS - 1; k++) begin
				histRe[k] <= '0;
				histIm[k] <= '0;
			end
			firValid <= 1'b0;
		end else if (sampleAccept) begin
			histRe[0] <= fifoRe;
			histIm[0] <= fifoIm;
			for (int k = 1; k < mfPkg::NUM_TAPS - 1; k++) begin
				histRe[k] <= histRe[k-1];
				histIm[k] <= histIm[k-1];
			end
			firValid <= 1'b1;
		end else if (firReady) begin
			firValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (sampleAccept) begin
			firRe <= shiftRe[mfPkg::OUT_WIDTH-1:0]; // upper bits only repeat the sign
			firIm <= shiftIm[mfPkg::OUT_WIDTH-1:0];
		end
	end

endmodule

//--- design/sampleFifo.sv
`timescale 1ns/1ps

module sampleFifo (
	input  logic                                clock,
	input  logic                                rstN,
	input  logic                                flush,

	input  logic                                inValid,
	output logic                                inReady,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] inRe,
	input  logic signed [mfPkg::DATA_WIDTH-1:0] inIm,

	output logic                                fifoValid,
	input  logic                                fifoReady,
	output logic signed [mfPkg::DATA_WIDTH-1:0] fifoRe,
	output logic signed [mfPkg::DATA_WIDTH-1:0] fifoIm
);

	logic signed [mfPkg::DATA_WIDTH-1:0] memRe [mfPkg::FIFO_DEPTH];
	logic signed [mfPkg::DATA_WIDTH-1:0] memIm [mfPkg::FIFO_DEPTH];

	logic [mfPkg::FIFO_PTR_WIDTH-1:0] wrPtr;
	logic [mfPkg::FIFO_PTR_WIDTH-1:0] rdPtr;
	logic [mfPkg::FIFO_CNT_WIDTH-1:0] count;

	logic fifoFull;
	logic doWrite;
	logic doRead;

	// wraps at FIFO_DEPTH, so the depth need not be a power of two
	function automatic logic [mfPkg::FIFO_PTR_WIDTH-1:0] nextPtr(
		input logic [mfPkg::FIFO_PTR_WIDTH-1:0] ptr
	);
		if (ptr == mfPkg::FIFO_PTR_WIDTH'(mfPkg::FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign fifoFull  = (count == mfPkg::FIFO_CNT_WIDTH'(mfPkg::FIFO_DEPTH));
	assign fifoValid = (count != '0);

	// a full buffer still takes a sample when the head leaves on the same edge
	assign inReady = !flush && (!fifoFull || fifoReady);
	assign doWrite = inValid && inReady;
	assign doRead  = fifoValid && fifoReady;

	assign fifoRe = memRe[rdPtr];
	assign fifoIm = memIm[rdPtr];

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) wrPtr <= nextPtr(wrPtr);
			if (doRead)  rdPtr <= nextPtr(rdPtr);
			case ({doWrite, doRead})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or one in and one out
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite) begin
			memRe[wrPtr] <= inRe;
			memIm[wrPtr] <= inIm;
		end
	end

endmodule

//--- design/coeffStore.sv
`timescale 1ns/1ps

module coeffStore (
	input  logic                                 clock,
	input  logic                                 rstN,
	input  logic                                 flush,

	input  logic                                 coeffValid,
	output logic                                 coeffReady,
	input  logic signed [mfPkg::DATA_WIDTH-1:0]  coeffRe,
	input  logic signed [mfPkg::DATA_WIDTH-1:0]  coeffIm,

	output logic                                 coeffsLoaded,
	output logic signed [mfPkg::DATA_WIDTH-1:0]  coefRe [mfPkg::NUM_TAPS],
	output logic signed [mfPkg::DATA_WIDTH-1:0]  coefIm [mfPkg::NUM_TAPS]
);

	logic [mfPkg::TAP_CNT_WIDTH-1:0] tapCount; // number of taps held so far
	logic                            coeffAccept;

	// the counter stops at NUM_TAPS, which is what marks the set as complete
	assign coeffsLoaded = (tapCount == mfPkg::TAP_CNT_WIDTH'(mfPkg::NUM_TAPS));
	assign coeffReady   = !coeffsLoaded && !flush;
	assign coeffAccept  = coeffValid && coeffReady;

	// ------------------------------
	// tap counter
	// ------------------------------
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			tapCount <= '0;
		end else if (flush) begin
			tapCount <= '0; // stored values become stale and are simply overwritten
		end else if (coeffAccept) begin
			tapCount <= tapCount + 1'b1;
		end
	end

	// ------------------------------
	// coefficient registers
	// ------------------------------
	// the counter value is the slot, so the first accepted coefficient is h[0]
	always_ff @(posedge clock) begin
		if (coeffAccept) begin
			coefRe[tapCount[mfPkg::TAP_IDX_WIDTH-1:0]] <= coeffRe;
			coefIm[tapCount[mfPkg::TAP_IDX_WIDTH-1:0]] <= coeffIm;
		end
	end

endmodule

//--- design/mfPkg.sv
package mfPkg;

	// ------------------------------
	// number formats
	// ------------------------------
	localparam int DATA_WIDTH = 16; // signed, the same for real and imaginary parts
	localparam int PROD_WIDTH = 2 * DATA_WIDTH;
	localparam int ACC_WIDTH  = 35; // one full product plus three growth bits
	localparam int FRAC_SHIFT = 15; // coefficients are treated as Q1.15

	// after the shift only OUT_WIDTH bits carry information
	localparam int OUT_WIDTH = 20;
	localparam int MAG_WIDTH = 21; // |re| + |im| needs one bit more than a component

	// ------------------------------
	// filter and buffer sizes
	// ------------------------------
	localparam int NUM_TAPS      = 8;
	localparam int TAP_IDX_WIDTH = $clog2(NUM_TAPS);
	localparam int TAP_CNT_WIDTH = $clog2(NUM_TAPS + 1); // counts up to NUM_TAPS inclusive

	localparam int FIFO_DEPTH     = 8;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	// ------------------------------
	// FIR control
	// ------------------------------
	// IDLE holds off the sample stream until a full coefficient set is present
	typedef enum logic {
		IDLE,
		RUN
	} filterStateT;

endpackage
